// ==== Bender.yml ====
package:
  name: attn_v

sources:
  - src/attn_cfg_pkg.sv
  - src/attn_mem_pkg.sv
  - src/shared_word_ram.sv
  - src/mem_arbiter.sv
  - src/host_write_port.sv
  - src/attn_v_engine.sv
  - src/lif_neuron_group.sv
  - src/attn_v_top.sv
  - target: test
    files:
      - dv/attn_v_tb.sv

// ==== all.f ====
src/attn_cfg_pkg.sv
src/attn_mem_pkg.sv
src/shared_word_ram.sv
src/mem_arbiter.sv
src/host_write_port.sv
src/attn_v_engine.sv
src/lif_neuron_group.sv
src/attn_v_top.sv
dv/attn_v_tb.sv

// ==== dv/attn_v_tb.sv ====
//**************************************************************************
// Testbench for the attention-times-value top level. Loads scores and
// value spikes through the host port, runs the engine and checks every
// output row against a reference model, with back-pressure and host traffic.
//**************************************************************************

`timescale 1ns/1ns

module attn_v_tb
    import attn_cfg_pkg::*;
    import attn_mem_pkg::*;
();

    localparam int N_RUNS          = 6;
    localparam int CYCLES_PER_ROW  = 200;
    localparam int LOAD_CYCLES     = 1000;
    localparam int WATCHDOG_CYCLES = N_RUNS * N_TOKENS * CYCLES_PER_ROW + LOAD_CYCLES;
    localparam int N_SCRATCH_WR    = 12;

    logic                    s_clk;
    logic                    s_rst;
    logic                    i_wr_valid;
    logic [ADDR_W-1:0]       i_wr_addr;
    logic [WORD_W-1:0]       i_wr_data;
    logic                    i_start;
    logic                    i_row_ready;
    logic                    o_wr_ready;
    logic                    o_busy;
    logic                    o_row_valid;
    logic [ROW_SPIKES_W-1:0] o_row_spikes;
    logic [ROW_IDX_W-1:0]    o_row_index;

    // shadow copy of the memory contents
    logic [WORD_W-1:0] score_mem [N_TOKENS];
    logic [WORD_W-1:0] value_mem [N_TOKENS];
    logic [WORD_W-1:0] got_rows  [N_TOKENS];
    logic [WORD_W-1:0] prev_rows [N_TOKENS];

    int rows_seen;
    int busy_writes;
    bit bp_on;

    attn_v_top i_dut (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_wr_valid   (i_wr_valid),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .i_start      (i_start),
        .i_row_ready  (i_row_ready),
        .o_wr_ready   (o_wr_ready),
        .o_busy       (o_busy),
        .o_row_valid  (o_row_valid),
        .o_row_spikes (o_row_spikes),
        .o_row_index  (o_row_index)
    );

    always #5 s_clk = ~s_clk;

    task automatic stop_on_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // sums per channel and step, then leaky integrate-and-fire over the steps
    function automatic logic [31:0] ref_row(input int row);
        int          psum;
        int          memb;
        logic [31:0] spk;
        spk = '0;
        for (int d = 0; d < N_CHANNELS; d++) begin
            memb = 0;
            for (int t = 0; t < T_STEPS; t++) begin
                psum = 0;
                for (int j = 0; j < N_TOKENS; j++) begin
                    if (value_mem[j][T_STEPS*d + t])
                        psum += score_mem[row][SCORE_W*j +: SCORE_W];
                end
                memb += psum;
                if (memb >= LIF_THRESHOLD) begin
                    spk[T_STEPS*d + t] = 1'b1;
                    memb = 0;
                end else begin
                    memb = memb / 2;
                end
            end
        end
        return spk;
    endfunction

    // returns one cycle after the word was taken
    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        bit done;
        @(posedge s_clk);
        #1;
        i_wr_valid = 1'b1;
        i_wr_addr  = addr;
        i_wr_data  = data;
        done       = 1'b0;
        while (!done) begin
            done = o_wr_ready;
            if (done && o_busy)
                busy_writes++;
            @(posedge s_clk);
            #1;
        end
        i_wr_valid = 1'b0;
    endtask

    task automatic drain_writes;
        do begin
            @(posedge s_clk);
            #1;
        end while (!o_wr_ready);
    endtask

    task automatic load_random;
        for (int i = 0; i < N_TOKENS; i++) begin
            score_mem[i] = $urandom;
            host_write(ATTN_BASE + ADDR_W'(i), score_mem[i]);
        end
        for (int i = 0; i < N_TOKENS; i++) begin
            value_mem[i] = $urandom;
            host_write(VALUE_BASE + ADDR_W'(i), value_mem[i]);
        end
        drain_writes();
    endtask

    task automatic fill_rows(input bit is_value, input logic [WORD_W-1:0] word);
        for (int i = 0; i < N_TOKENS; i++) begin
            if (is_value) begin
                value_mem[i] = word;
                host_write(VALUE_BASE + ADDR_W'(i), word);
            end else begin
                score_mem[i] = word;
                host_write(ATTN_BASE + ADDR_W'(i), word);
            end
        end
        drain_writes();
    endtask

    task automatic scratch_writes(input int n);
        logic [ADDR_W-1:0] addr;
        // let the run get going first
        repeat (4) @(posedge s_clk);
        for (int k = 0; k < n; k++) begin
            addr = ADDR_W'(16 + ($urandom % 16));
            host_write(addr, $urandom);
        end
    endtask

    task automatic run_once(input bit extra_start);
        rows_seen = 0;
        @(posedge s_clk);
        #1;
        check_eq(o_busy, 1'b0, "busy before start");
        i_start = 1'b1;
        @(posedge s_clk);
        #1;
        i_start = 1'b0;
        check_eq(o_busy, 1'b1, "busy after start");
        if (extra_start) begin
            repeat (20) @(posedge s_clk);
            #1;
            check_eq(o_busy, 1'b1, "busy at second start pulse");
            i_start = 1'b1;
            @(posedge s_clk);
            #1;
            i_start = 1'b0;
        end
        while (o_busy) begin
            @(posedge s_clk);
            #1;
        end
        check_eq(rows_seen, N_TOKENS, "rows per run");
    endtask

    // output ready is random while back-pressure is on
    initial begin
        forever begin
            @(posedge s_clk);
            #1;
            if (bp_on)
                i_row_ready = ($urandom % 3) != 0;
            else
                i_row_ready = 1'b1;
        end
    end

    // comparator sampled at the falling edge
    initial begin
        logic                    held;
        logic [ROW_SPIKES_W-1:0] held_spikes;
        logic [ROW_IDX_W-1:0]    held_idx;
        held = 1'b0;
        forever begin
            @(negedge s_clk);
            if (held) begin
                check_eq(o_row_valid, 1'b1, "valid dropped while stalled");
                check_eq(o_row_spikes, held_spikes, "spikes changed while stalled");
                check_eq(o_row_index, held_idx, "index changed while stalled");
            end
            if (!s_rst && o_row_valid && i_row_ready) begin
                if (rows_seen >= N_TOKENS) begin
                    stop_on_error("an output row came out beyond the eight of a run");
                end else begin
                    check_eq(o_row_index, rows_seen, "row index order");
                    check_eq(o_row_spikes, ref_row(rows_seen), "row spikes vs reference");
                    got_rows[rows_seen] = o_row_spikes;
                    rows_seen++;
                end
            end
            held        = o_row_valid && !i_row_ready;
            held_spikes = o_row_spikes;
            held_idx    = o_row_index;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge s_clk);
        stop_on_error($sformatf("timeout, the run did not end within %0d cycles",
                                WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'h8f07));
        s_clk       = 1'b0;
        s_rst       = 1'b1;
        i_wr_valid  = 1'b0;
        i_wr_addr   = '0;
        i_wr_data   = '0;
        i_start     = 1'b0;
        i_row_ready = 1'b1;
        bp_on       = 1'b0;
        rows_seen   = 0;
        busy_writes = 0;
        repeat (8) @(posedge s_clk);
        #1;
        s_rst = 1'b0;

        check_eq(o_busy, 1'b0, "busy after reset");
        check_eq(o_row_valid, 1'b0, "row valid after reset");
        check_eq(o_wr_ready, 1'b1, "write ready after reset");

        // random data with free-running output
        load_random();
        run_once(1'b0);
        for (int i = 0; i < N_TOKENS; i++)
            prev_rows[i] = got_rows[i];

        // same data under back-pressure
        bp_on = 1'b1;
        run_once(1'b0);
        bp_on = 1'b0;
        for (int i = 0; i < N_TOKENS; i++)
            check_eq(got_rows[i], prev_rows[i], "row under back-pressure");

        // scratch traffic from the host during a run
        busy_writes = 0;
        fork
            run_once(1'b0);
            scratch_writes(N_SCRATCH_WR);
        join
        check_eq(busy_writes, N_SCRATCH_WR, "scratch writes taken while busy");
        for (int i = 0; i < N_TOKENS; i++)
            check_eq(got_rows[i], prev_rows[i], "row with host traffic");

        // no input spikes at all
        fill_rows(1'b1, 32'h0000_0000);
        run_once(1'b0);
        for (int i = 0; i < N_TOKENS; i++)
            check_eq(got_rows[i], 32'h0000_0000, "row with zero values");

        // full scores and spikes saturate every neuron
        fill_rows(1'b0, 32'hffff_ffff);
        fill_rows(1'b1, 32'hffff_ffff);
        run_once(1'b0);
        for (int i = 0; i < N_TOKENS; i++)
            check_eq(got_rows[i], 32'hffff_ffff, "row with full values");

        // second start while busy must be dropped
        run_once(1'b1);
        repeat (40) @(posedge s_clk);
        #1;
        check_eq(o_busy, 1'b0, "busy after ignored start");

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== src/attn_cfg_pkg.sv ====
//**************************************************************************
// Sizes and neuron constants of the attention-times-value engine.
// Modules that handle scores, sums or spikes import this package.
//**************************************************************************

package attn_cfg_pkg;

    // problem dimensions
    localparam int unsigned N_TOKENS   = 8;
    localparam int unsigned N_CHANNELS = 8;
    localparam int unsigned T_STEPS    = 4;

    // one unsigned attention score
    localparam int unsigned SCORE_W = 4;

    // 8 products of at most 15 fit in 7 bits
    localparam int unsigned PSUM_W = 7;

    // partial sums for one row in channel-major then time-step order
    localparam int unsigned PSUM_BUS_W = N_CHANNELS * T_STEPS * PSUM_W;

    // neuron membrane and firing level
    localparam int unsigned MEMB_W        = 9;
    localparam int unsigned LIF_THRESHOLD = 40;

    // one output row and its index
    localparam int unsigned ROW_SPIKES_W = N_CHANNELS * T_STEPS;
    localparam int unsigned ROW_IDX_W    = $clog2(N_TOKENS);

endpackage

// ==== src/attn_mem_pkg.sv ====
//**************************************************************************
// Memory map of the shared word memory and the two views of one word.
// Memory-side modules and the engine import this package.
//**************************************************************************

package attn_mem_pkg;

    import attn_cfg_pkg::*;

    localparam int unsigned MEM_DEPTH = 32;
    localparam int unsigned ADDR_W    = 5;
    localparam int unsigned WORD_W    = 32;

    // words 0..7 attention rows, 8..15 value rows, 16..31 scratch
    localparam logic [ADDR_W-1:0] ATTN_BASE  = 5'd0;
    localparam logic [ADDR_W-1:0] VALUE_BASE = 5'd8;

    // requester index and the arbiter's last-grant encoding
    localparam logic HOST_REQ   = 1'b0;
    localparam logic ENGINE_REQ = 1'b1;

    // score j sits in bits 4j+3:4j
    // spike of channel d at step t sits in bit 4d+t
    typedef union packed {
        logic [N_TOKENS-1:0][SCORE_W-1:0]   attn_row;
        logic [N_CHANNELS-1:0][T_STEPS-1:0] value_row;
    } mem_word_u;

endpackage

// ==== src/attn_v_engine.sv ====
//**************************************************************************
// Sequencer and MAC core. Per attention row it reads the score word, then
// the eight value words, and offers the partial sums to the neuron group.
//**************************************************************************

`timescale 1ns/1ns

module attn_v_engine
    import attn_cfg_pkg::*;
    import attn_mem_pkg::*;
(
    input  logic                 s_clk,
    input  logic                 s_rst,
    input  logic                 i_start,
    input  logic                 i_gnt,
    input  logic [WORD_W-1:0]    i_rdata,
    input  logic                 i_psum_ready,
    input  logic                 i_last_done,
    output logic                 o_req,
    output logic [ADDR_W-1:0]    o_addr,
    output logic                 o_busy,
    output logic                 o_psum_valid,
    output logic [PSUM_BUS_W-1:0] o_psum_data,
    output logic [ROW_IDX_W-1:0] o_row_index
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_SCORE_RD = 3'd1;
    localparam logic [2:0] S_VALUE_RD = 3'd2;
    localparam logic [2:0] S_EMIT     = 3'd3;
    localparam logic [2:0] S_FINISH   = 3'd4;

    localparam logic [ROW_IDX_W-1:0] LAST_IDX = ROW_IDX_W'(N_TOKENS - 1);

    logic [2:0]           state_q;
    logic [ROW_IDX_W-1:0] row_q;
    logic [ROW_IDX_W-1:0] col_q;
    logic                 rd_pend_q;
    logic                 rd_done;
    mem_word_u            rd_word;
    mem_word_u            scores_q;

    logic [N_CHANNELS-1:0][T_STEPS-1:0][PSUM_W-1:0] psum_q;

    assign rd_word = i_rdata;

    // read data is valid the cycle after the grant
    assign rd_done = rd_pend_q && (state_q == S_SCORE_RD || state_q == S_VALUE_RD);

    assign o_req  = (state_q == S_SCORE_RD || state_q == S_VALUE_RD) && !rd_pend_q;
    assign o_addr = (state_q == S_SCORE_RD) ? ATTN_BASE + ADDR_W'(row_q)
                                            : VALUE_BASE + ADDR_W'(col_q);

    assign o_busy       = state_q != S_IDLE;
    assign o_psum_valid = state_q == S_EMIT;
    assign o_psum_data  = psum_q;
    assign o_row_index  = row_q;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state_q   <= S_IDLE;
            row_q     <= '0;
            col_q     <= '0;
            rd_pend_q <= 1'b0;
        end else begin
            if (o_req && i_gnt) begin
                rd_pend_q <= 1'b1;
            end else if (rd_done) begin
                rd_pend_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: begin
                    if (i_start) begin
                        row_q   <= '0;
                        state_q <= S_SCORE_RD;
                    end
                end
                S_SCORE_RD: begin
                    if (rd_done) begin
                        col_q   <= '0;
                        state_q <= S_VALUE_RD;
                    end
                end
                S_VALUE_RD: begin
                    if (rd_done) begin
                        col_q <= col_q + 1'b1;
                        if (col_q == LAST_IDX) begin
                            state_q <= S_EMIT;
                        end
                    end
                end
                S_EMIT: begin
                    // stall here until the neurons take the row
                    if (i_psum_ready) begin
                        if (row_q == LAST_IDX) begin
                            state_q <= S_FINISH;
                        end else begin
                            row_q   <= row_q + 1'b1;
                            state_q <= S_SCORE_RD;
                        end
                    end
                end
                S_FINISH: begin
                    if (i_last_done) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // score row kept for the whole row; sums restart with each score read
    always_ff @(posedge s_clk) begin
        if (rd_done && state_q == S_SCORE_RD) begin
            scores_q <= rd_word;
            psum_q   <= '0;
        end else if (rd_done && state_q == S_VALUE_RD) begin
            for (int d = 0; d < N_CHANNELS; d++) begin
                for (int t = 0; t < T_STEPS; t++) begin
                    if (rd_word.value_row[d][t]) begin
                        psum_q[d][t] <= psum_q[d][t] + PSUM_W'(scores_q.attn_row[col_q]);
                    end
                end
            end
        end
    end

endmodule

// ==== src/attn_v_top.sv ====
//**************************************************************************
// Top level of the attention-times-value engine. The host writes scores
// and value spikes, pulses start, and collects one spike row per token.
//**************************************************************************

`timescale 1ns/1ns

module attn_v_top
    import attn_cfg_pkg::*;
    import attn_mem_pkg::*;
(
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_wr_valid,
    input  logic [ADDR_W-1:0]       i_wr_addr,
    input  logic [WORD_W-1:0]       i_wr_data,
    input  logic                    i_start,
    input  logic                    i_row_ready,
    output logic                    o_wr_ready,
    output logic                    o_busy,
    output logic                    o_row_valid,
    output logic [ROW_SPIKES_W-1:0] o_row_spikes,
    output logic [ROW_IDX_W-1:0]    o_row_index
);

    logic                  host_req;
    logic                  host_gnt;
    logic [ADDR_W-1:0]     host_addr;
    logic [WORD_W-1:0]     host_wdata;
    logic                  eng_req;
    logic                  eng_gnt;
    logic [ADDR_W-1:0]     eng_addr;
    logic                  mem_en;
    logic                  mem_we;
    logic [ADDR_W-1:0]     mem_addr;
    logic [WORD_W-1:0]     mem_wdata;
    logic [WORD_W-1:0]     mem_rdata;
    logic                  psum_valid;
    logic                  psum_ready;
    logic [PSUM_BUS_W-1:0] psum_data;
    logic [ROW_IDX_W-1:0]  psum_index;
    logic                  last_done;

    shared_word_ram i_ram (
        .s_clk   (s_clk),
        .i_en    (mem_en),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    mem_arbiter i_arbiter (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_host_req   (host_req),
        .i_host_addr  (host_addr),
        .i_host_wdata (host_wdata),
        .i_eng_req    (eng_req),
        .i_eng_addr   (eng_addr),
        .o_host_gnt   (host_gnt),
        .o_eng_gnt    (eng_gnt),
        .o_mem_en     (mem_en),
        .o_mem_we     (mem_we),
        .o_mem_addr   (mem_addr),
        .o_mem_wdata  (mem_wdata)
    );

    host_write_port i_host_port (
        .s_clk      (s_clk),
        .s_rst      (s_rst),
        .i_wr_valid (i_wr_valid),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .i_gnt      (host_gnt),
        .o_wr_ready (o_wr_ready),
        .o_req      (host_req),
        .o_addr     (host_addr),
        .o_wdata    (host_wdata)
    );

    attn_v_engine i_engine (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_start      (i_start),
        .i_gnt        (eng_gnt),
        .i_rdata      (mem_rdata),
        .i_psum_ready (psum_ready),
        .i_last_done  (last_done),
        .o_req        (eng_req),
        .o_addr       (eng_addr),
        .o_busy       (o_busy),
        .o_psum_valid (psum_valid),
        .o_psum_data  (psum_data),
        .o_row_index  (psum_index)
    );

    lif_neuron_group i_neurons (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_psum_valid (psum_valid),
        .i_psum_data  (psum_data),
        .i_row_index  (psum_index),
        .i_row_ready  (i_row_ready),
        .o_psum_ready (psum_ready),
        .o_row_valid  (o_row_valid),
        .o_row_spikes (o_row_spikes),
        .o_row_index  (o_row_index),
        .o_last_done  (last_done)
    );

endmodule

// ==== src/host_write_port.sv ====
//**************************************************************************
// Host write port with a one-entry buffer.
// Takes a word under valid/ready and requests the arbiter until granted.
//**************************************************************************

`timescale 1ns/1ns

module host_write_port
    import attn_mem_pkg::*;
(
    input  logic              s_clk,
    input  logic              s_rst,
    input  logic              i_wr_valid,
    input  logic [ADDR_W-1:0] i_wr_addr,
    input  logic [WORD_W-1:0] i_wr_data,
    input  logic              i_gnt,
    output logic              o_wr_ready,
    output logic              o_req,
    output logic [ADDR_W-1:0] o_addr,
    output logic [WORD_W-1:0] o_wdata
);

    logic              full_q;
    logic [ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0] data_q;
    logic              accept;

    assign o_wr_ready = !full_q;
    assign accept     = i_wr_valid && o_wr_ready;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (i_gnt) begin
            full_q <= 1'b0;
        end
    end

    // buffered word
    always_ff @(posedge s_clk) begin
        if (accept) begin
            addr_q <= i_wr_addr;
            data_q <= i_wr_data;
        end
    end

    assign o_req   = full_q;
    assign o_addr  = addr_q;
    assign o_wdata = data_q;

endmodule

// ==== src/lif_neuron_group.sv ====
//**************************************************************************
// One leaky integrate-and-fire neuron per channel, stepped over time.
// The spike row is registered and offered under valid/ready.
//**************************************************************************

`timescale 1ns/1ns

module lif_neuron_group
    import attn_cfg_pkg::*;
(
    input  logic                    s_clk,
    input  logic                    s_rst,
    input  logic                    i_psum_valid,
    input  logic [PSUM_BUS_W-1:0]   i_psum_data,
    input  logic [ROW_IDX_W-1:0]    i_row_index,
    input  logic                    i_row_ready,
    output logic                    o_psum_ready,
    output logic                    o_row_valid,
    output logic [ROW_SPIKES_W-1:0] o_row_spikes,
    output logic [ROW_IDX_W-1:0]    o_row_index,
    output logic                    o_last_done
);

    logic [N_CHANNELS-1:0][T_STEPS-1:0][PSUM_W-1:0] psum_arr;
    logic [N_CHANNELS-1:0][T_STEPS-1:0]             spikes_next;
    logic                                           take;

    // membrane starts at zero each row; fire and reset, else leak by half
    function automatic logic [T_STEPS-1:0] lif_run(input logic [T_STEPS-1:0][PSUM_W-1:0] sums);
        logic [MEMB_W-1:0]  memb;
        logic [T_STEPS-1:0] spk;
        memb = '0;
        spk  = '0;
        for (int t = 0; t < T_STEPS; t++) begin
            memb = memb + MEMB_W'(sums[t]);
            if (memb >= MEMB_W'(LIF_THRESHOLD)) begin
                spk[t] = 1'b1;
                memb   = '0;
            end else begin
                memb = memb >> 1;
            end
        end
        return spk;
    endfunction

    assign psum_arr = i_psum_data;

    always_comb begin
        for (int d = 0; d < N_CHANNELS; d++) begin
            spikes_next[d] = lif_run(psum_arr[d]);
        end
    end

    assign o_psum_ready = !o_row_valid || i_row_ready;
    assign take         = i_psum_valid && o_psum_ready;
    assign o_last_done  = o_row_valid && i_row_ready && o_row_index == ROW_IDX_W'(N_TOKENS - 1);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_row_valid <= 1'b0;
        end else if (take) begin
            o_row_valid <= 1'b1;
        end else if (i_row_ready) begin
            o_row_valid <= 1'b0;
        end
    end

    always_ff @(posedge s_clk) begin
        if (take) begin
            o_row_spikes <= spikes_next;
            o_row_index  <= i_row_index;
        end
    end

endmodule

// ==== src/mem_arbiter.sv ====
//**************************************************************************
// Round-robin arbiter for the shared memory.
// The host only writes and the engine only reads; grants last one cycle.
//**************************************************************************

`timescale 1ns/1ns

module mem_arbiter
    import attn_mem_pkg::*;
(
    input  logic              s_clk,
    input  logic              s_rst,
    input  logic              i_host_req,
    input  logic [ADDR_W-1:0] i_host_addr,
    input  logic [WORD_W-1:0] i_host_wdata,
    input  logic              i_eng_req,
    input  logic [ADDR_W-1:0] i_eng_addr,
    output logic              o_host_gnt,
    output logic              o_eng_gnt,
    output logic              o_mem_en,
    output logic              o_mem_we,
    output logic [ADDR_W-1:0] o_mem_addr,
    output logic [WORD_W-1:0] o_mem_wdata
);

    logic last_gnt_q;
    logic host_win;

    // host wins when alone or when the engine had the last grant
    assign host_win   = i_host_req && (!i_eng_req || last_gnt_q == ENGINE_REQ);
    assign o_host_gnt = host_win;
    assign o_eng_gnt  = i_eng_req && !host_win;

    assign o_mem_en    = o_host_gnt || o_eng_gnt;
    assign o_mem_we    = host_win;
    assign o_mem_addr  = host_win ? i_host_addr : i_eng_addr;
    assign o_mem_wdata = i_host_wdata;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            last_gnt_q <= HOST_REQ;
        end else if (o_mem_en) begin
            last_gnt_q <= host_win ? HOST_REQ : ENGINE_REQ;
        end
    end

endmodule

// ==== src/shared_word_ram.sv ====
//**************************************************************************
// Single-port word memory shared by the host and the engine.
// Read data is registered and valid the cycle after an enabled read.
//**************************************************************************

`timescale 1ns/1ns

module shared_word_ram
    import attn_mem_pkg::*;
(
    input  logic              s_clk,
    input  logic              i_en,
    input  logic              i_we,
    input  logic [ADDR_W-1:0] i_addr,
    input  logic [WORD_W-1:0] i_wdata,
    output logic [WORD_W-1:0] o_rdata
);

    logic [WORD_W-1:0] mem_q [MEM_DEPTH];

    always_ff @(posedge s_clk) begin
        if (i_en) begin
            if (i_we) begin
                mem_q[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem_q[i_addr];
            end
        end
    end

endmodule
